/* flist.f */
rtl/sram_spi_pkg.sv
rtl/sck_gen.sv
rtl/spi_shift_path.sv
rtl/spi_sram_fsm.sv
rtl/spi_sram_ctrl.sv
test/spi_sram_model.sv
test/tb_spi_sram_ctrl.sv

/* rtl/sck_gen.sv */
/*
 * SPI serial clock generator.
 * Divides clk by CLK_SCK_RATIO into a mode 0 SCK and a one-cycle bit
 * strobe that lands one cycle before the end of each SCK period.
 */
`timescale 1ns/10ps
`default_nettype none

module sck_gen #(
    parameter int CLK_SCK_RATIO = 6
) (
    input  wire   clk,
    input  wire   reset_n,
    input  wire   sync_reset,
    input  wire   sck_on,
    input  wire   sck_off,
    output logic  mem_sck,
    output logic  sck_pulse
);

    localparam int CW = $clog2(CLK_SCK_RATIO);
    localparam logic [CW-1:0] CNT_LAST  = CW'(CLK_SCK_RATIO - 1);
    localparam logic [CW-1:0] CNT_PULSE = CW'(CLK_SCK_RATIO - 2);
    localparam logic [CW-1:0] CNT_HALF  = CW'(CLK_SCK_RATIO / 2);

    logic           sck_en;
    logic [CW-1:0]  sck_cnt;

    if ((CLK_SCK_RATIO < 4) || (CLK_SCK_RATIO % 2 != 0)) begin : g_ratio_check
        $error("CLK_SCK_RATIO must be even and at least 4");
    end

    // abort wins over a start request
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sck_en <= 1'b0;
        end else if (sync_reset || sck_off) begin
            sck_en <= 1'b0;
        end else if (sck_on) begin
            sck_en <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sck_cnt <= '0;
        end else if (sync_reset || !sck_en || (sck_cnt == CNT_LAST)) begin
            sck_cnt <= '0;
        end else begin
            sck_cnt <= sck_cnt + 1'b1;
        end
    end

    // low for the first half of a period, high for the second
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_sck   <= 1'b0;
            sck_pulse <= 1'b0;
        end else begin
            mem_sck   <= sck_en && (sck_cnt >= CNT_HALF);
            sck_pulse <= sck_en && (sck_cnt == CNT_PULSE);
        end
    end

    a_sck_idle_low : assert property (
        @(posedge clk) disable iff (!reset_n) !sck_en |=> !mem_sck
    );

endmodule : sck_gen

`default_nettype wire

/* rtl/spi_shift_path.sv */
/*
 * Data path of the SPI SRAM controller.
 * Loads opcode, address and write byte from the host, shifts the selected
 * one MSB first onto SI and gathers read bytes from SO for the host.
 */
`timescale 1ns/10ps
`default_nettype none

module spi_shift_path import sram_spi_pkg::*; (
    input  wire         clk,
    input  wire         reset_n,

    // host side
    input  wire         instruction_start,
    input  byte_t       instruction,
    input  sram_addr_t  address,
    input  byte_t       write_data,
    output logic        write_data_grasp,
    output byte_t       read_data,
    output logic        read_data_enable_out,

    // from the sequencer
    input  wire         sck_pulse,
    input  wire [1:0]   shift_sel,
    input  wire         shift_read,
    input  wire         grasp,
    input  wire         byte_done,

    // back to the sequencer
    output byte_t       opcode,
    output sram_mode_e  mode_field,

    // memory pins
    input  wire         mem_so,
    output logic        mem_si
);

    sram_addr_t  addr_sr;
    wr_byte_u    wr_byte;
    byte_t       rd_sr;
    logic        rd_done_d1;

    // ============================================================
    // outgoing shift registers
    // ============================================================
    always_ff @(posedge clk) begin
        if (instruction_start) begin
            opcode <= instruction;
        end else if ((shift_sel == SEL_OPCODE) && sck_pulse) begin
            opcode <= {opcode[BITS_PER_BYTE-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (instruction_start) begin
            addr_sr <= address;
        end else if ((shift_sel == SEL_ADDR) && sck_pulse) begin
            addr_sr <= {addr_sr[$high(addr_sr)-1:0], 1'b0};
        end
    end

    // reload for the next streamed byte wins over the last shift
    always_ff @(posedge clk) begin
        if (instruction_start || grasp) begin
            wr_byte.data <= write_data;
        end else if ((shift_sel == SEL_WDATA) && sck_pulse) begin
            wr_byte.data <= {wr_byte.data[BITS_PER_BYTE-2:0], 1'b0};
        end
    end

    assign mode_field = wr_byte.mode_reg.mode;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_data_grasp <= 1'b0;
        end else begin
            write_data_grasp <= instruction_start || grasp;
        end
    end

    // SI follows the selected MSB, holds between stages
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_si <= 1'b0;
        end else begin
            case (shift_sel)
                SEL_OPCODE: mem_si <= opcode[BITS_PER_BYTE-1];
                SEL_ADDR:   mem_si <= addr_sr[$high(addr_sr)];
                SEL_WDATA:  mem_si <= wr_byte.data[BITS_PER_BYTE-1];
                default:    mem_si <= mem_si;
            endcase
        end
    end

    // ============================================================
    // read side
    // ============================================================
    // SO is stable by the strobe, which sits in the high half of SCK
    always_ff @(posedge clk) begin
        if (shift_read && sck_pulse) begin
            rd_sr <= {rd_sr[BITS_PER_BYTE-2:0], mem_so};
        end
    end

    always_ff @(posedge clk) begin
        if (rd_done_d1) begin
            read_data <= rd_sr;
        end
    end

    // enable lands with the data, two cycles after the last bit strobe
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_done_d1           <= 1'b0;
            read_data_enable_out <= 1'b0;
        end else begin
            rd_done_d1           <= byte_done && shift_read;
            read_data_enable_out <= rd_done_d1;
        end
    end

endmodule : spi_shift_path

`default_nettype wire

/* rtl/spi_sram_ctrl.sv */
/*
 * Host-side controller for a 1 Mbit serial SPI SRAM.
 * Runs WRMR, WRITE and READ in byte or sequential mode on a single-bit
 * SPI bus; CLK_SCK_RATIO sets the SCK divide from clk.
 */
`timescale 1ns/10ps
`default_nettype none

module spi_sram_ctrl import sram_spi_pkg::*; #(
    parameter int CLK_SCK_RATIO = 6
) (
    input  wire         clk,
    input  wire         reset_n,
    input  wire         sync_reset,

    // host side
    input  wire         instruction_start,
    input  byte_t       instruction,
    input  sram_addr_t  address,
    input  byte_t       write_data,
    output logic        write_data_grasp,
    output logic        read_data_enable_out,
    output byte_t       read_data,

    // memory pins
    input  wire         mem_so,
    output logic        mem_si,
    output logic        mem_hold_n,
    output logic        mem_cs_n,
    output logic        mem_sck
);

    logic        sck_pulse;
    logic        sck_on;
    logic        sck_off;
    logic        load;
    logic [1:0]  shift_sel;
    logic        shift_read;
    logic        grasp;
    logic        byte_done;
    byte_t       opcode;
    sram_mode_e  mode_field;

    // hold is never used
    assign mem_hold_n = 1'b1;

    sck_gen #(
        .CLK_SCK_RATIO (CLK_SCK_RATIO)
    ) i_sck_gen (
        .clk        (clk),
        .reset_n    (reset_n),
        .sync_reset (sync_reset),
        .sck_on     (sck_on),
        .sck_off    (sck_off),
        .mem_sck    (mem_sck),
        .sck_pulse  (sck_pulse)
    );

    // loads are taken only when the sequencer accepts the start
    spi_shift_path i_spi_shift_path (
        .clk                  (clk),
        .reset_n              (reset_n),
        .instruction_start    (load),
        .instruction          (instruction),
        .address              (address),
        .write_data           (write_data),
        .write_data_grasp     (write_data_grasp),
        .read_data            (read_data),
        .read_data_enable_out (read_data_enable_out),
        .sck_pulse            (sck_pulse),
        .shift_sel            (shift_sel),
        .shift_read           (shift_read),
        .grasp                (grasp),
        .byte_done            (byte_done),
        .opcode               (opcode),
        .mode_field           (mode_field),
        .mem_so               (mem_so),
        .mem_si               (mem_si)
    );

    spi_sram_fsm i_spi_sram_fsm (
        .clk               (clk),
        .reset_n           (reset_n),
        .sync_reset        (sync_reset),
        .instruction_start (instruction_start),
        .opcode            (opcode),
        .mode_field        (mode_field),
        .sck_pulse         (sck_pulse),
        .mem_cs_n          (mem_cs_n),
        .sck_on            (sck_on),
        .sck_off           (sck_off),
        .load              (load),
        .shift_sel         (shift_sel),
        .shift_read        (shift_read),
        .grasp             (grasp),
        .byte_done         (byte_done)
    );

endmodule : spi_sram_ctrl

`default_nettype wire

/* rtl/spi_sram_fsm.sv */
/*
 * Transfer sequencer for the SPI SRAM controller.
 * One-hot FSM that walks opcode, address and data stages, drives chip
 * select and SCK enables, and keeps the device mode register copy.
 */
`timescale 1ns/10ps
`default_nettype none

module spi_sram_fsm import sram_spi_pkg::*; (
    input  wire         clk,
    input  wire         reset_n,
    input  wire         sync_reset,
    input  wire         instruction_start,
    input  byte_t       opcode,
    input  sram_mode_e  mode_field,
    input  wire         sck_pulse,
    output logic        mem_cs_n,
    output logic        sck_on,
    output logic        sck_off,
    output logic        load,
    output logic [1:0]  shift_sel,
    output logic        shift_read,
    output logic        grasp,
    output logic        byte_done
);

    localparam int S_IDLE         = 0;
    localparam int S_INSTRUCTION  = 1;
    localparam int S_OPCODE       = 2;
    localparam int S_AFTER_OPCODE = 3;
    localparam int S_ADDR_2       = 4;
    localparam int S_ADDR_1       = 5;
    localparam int S_ADDR_0       = 6;
    localparam int S_AFTER_ADDR   = 7;
    localparam int S_WRITE        = 8;
    localparam int S_READ         = 9;
    localparam int NUM_STATES     = 10;

    logic [NUM_STATES-1:0]  state;
    logic [NUM_STATES-1:0]  next_state;
    logic [3:0]             bit_cnt;
    logic                   bit_last;
    logic                   cnt_load;
    logic                   cs_high;
    logic                   cs_low;
    logic                   addr_stage;
    logic                   wr_stage;
    logic                   rd_stage;
    sram_mode_e             mode_q;
    logic                   stream;

    assign bit_last = sck_pulse && (bit_cnt == 4'd1);
    // page mode streams too, no wrap is modelled
    assign stream   = addr_stage && (mode_q != MODE_BYTE);
    assign load     = instruction_start && state[S_IDLE];

    // ============================================================
    // state and support registers
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= NUM_STATES'(1) << S_IDLE;
        end else if (sync_reset) begin
            state <= NUM_STATES'(1) << S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt <= '0;
        end else if (cnt_load) begin
            bit_cnt <= 4'(BITS_PER_BYTE);
        end else if (sck_pulse) begin
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    // stage flags from the opcode decode
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            addr_stage <= 1'b0;
            wr_stage   <= 1'b0;
            rd_stage   <= 1'b0;
        end else if (state[S_IDLE]) begin
            addr_stage <= 1'b0;
            wr_stage   <= 1'b0;
            rd_stage   <= 1'b0;
        end else if (state[S_INSTRUCTION]) begin
            addr_stage <= (opcode == CMD_WRITE) || (opcode == CMD_READ);
            wr_stage   <= (opcode == CMD_WRITE) || (opcode == CMD_WRMR);
            rd_stage   <= (opcode == CMD_READ);
        end
    end

    // powers up in sequential mode like the device
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode_q <= MODE_SEQ;
        end else if (state[S_INSTRUCTION] && (opcode == CMD_WRMR)) begin
            mode_q <= mode_field;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_cs_n <= 1'b1;
        end else if (sync_reset || cs_high) begin
            mem_cs_n <= 1'b1;
        end else if (cs_low) begin
            mem_cs_n <= 1'b0;
        end
    end

    // ============================================================
    // next state and controls
    // ============================================================
    always_comb begin
        next_state = '0;
        cnt_load   = 1'b0;
        cs_high    = 1'b0;
        cs_low     = 1'b0;
        sck_on     = 1'b0;
        sck_off    = 1'b0;
        shift_sel  = SEL_NONE;
        shift_read = 1'b0;
        grasp      = 1'b0;
        byte_done  = 1'b0;

        case (1'b1)
            state[S_IDLE]: begin
                cs_high = 1'b1;
                sck_off = 1'b1;
                next_state[instruction_start ? S_INSTRUCTION : S_IDLE] = 1'b1;
            end
            state[S_INSTRUCTION]: begin
                cs_low   = 1'b1;
                sck_on   = 1'b1;
                cnt_load = 1'b1;
                next_state[S_OPCODE] = 1'b1;
            end
            state[S_OPCODE]: begin
                shift_sel = SEL_OPCODE;
                next_state[bit_last ? S_AFTER_OPCODE : S_OPCODE] = 1'b1;
            end
            state[S_AFTER_OPCODE]: begin
                cnt_load = 1'b1;
                next_state[addr_stage ? S_ADDR_2 : S_AFTER_ADDR] = 1'b1;
            end
            state[S_ADDR_2]: begin
                shift_sel = SEL_ADDR;
                cnt_load  = bit_last;
                next_state[bit_last ? S_ADDR_1 : S_ADDR_2] = 1'b1;
            end
            state[S_ADDR_1]: begin
                shift_sel = SEL_ADDR;
                cnt_load  = bit_last;
                next_state[bit_last ? S_ADDR_0 : S_ADDR_1] = 1'b1;
            end
            state[S_ADDR_0]: begin
                shift_sel = SEL_ADDR;
                next_state[bit_last ? S_AFTER_ADDR : S_ADDR_0] = 1'b1;
            end
            state[S_AFTER_ADDR]: begin
                cnt_load = 1'b1;
                if (wr_stage) begin
                    next_state[S_WRITE] = 1'b1;
                end else if (rd_stage) begin
                    next_state[S_READ] = 1'b1;
                end else begin
                    // unknown opcode, nothing left to send
                    cs_high = 1'b1;
                    sck_off = 1'b1;
                    next_state[S_IDLE] = 1'b1;
                end
            end
            state[S_WRITE]: begin
                shift_sel = SEL_WDATA;
                byte_done = bit_last;
                if (bit_last && !stream) begin
                    cs_high = 1'b1;
                    sck_off = 1'b1;
                    next_state[S_IDLE] = 1'b1;
                end else begin
                    cnt_load = bit_last;
                    grasp    = bit_last;
                    next_state[S_WRITE] = 1'b1;
                end
            end
            state[S_READ]: begin
                shift_read = 1'b1;
                byte_done  = bit_last;
                if (bit_last && !stream) begin
                    cs_high = 1'b1;
                    sck_off = 1'b1;
                    next_state[S_IDLE] = 1'b1;
                end else begin
                    cnt_load = bit_last;
                    next_state[S_READ] = 1'b1;
                end
            end
            default: begin
                next_state[S_IDLE] = 1'b1;
            end
        endcase
    end

    a_state_onehot : assert property (
        @(posedge clk) disable iff (!reset_n) $onehot(state)
    );

    // a start while busy must not restart the sequence
    a_start_in_idle : assert property (
        @(posedge clk) disable iff (!reset_n)
        (instruction_start && !state[S_IDLE] && !state[S_INSTRUCTION])
            |=> !state[S_INSTRUCTION]
    );

endmodule : spi_sram_fsm

`default_nettype wire

/* rtl/sram_spi_pkg.sv */
/*
 * Shared definitions for the serial SPI SRAM controller.
 * Holds opcodes, mode encodings, widths and the host write byte union.
 * Imported by the RTL blocks and the testbench.
 */
`default_nettype none

package sram_spi_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int BITS_PER_BYTE = 8;
    localparam int ADDR_BYTES    = 3;

    typedef logic unsigned [BITS_PER_BYTE-1:0]            byte_t;
    typedef logic unsigned [ADDR_BYTES*BITS_PER_BYTE-1:0] sram_addr_t;

    // ============================================================
    // instruction set
    // ============================================================
    localparam byte_t CMD_WRMR  = 8'h01;
    localparam byte_t CMD_WRITE = 8'h02;
    localparam byte_t CMD_READ  = 8'h03;

    // mode field of the device mode register, page mode runs like sequential
    typedef enum logic [1:0] {
        MODE_BYTE = 2'd0,
        MODE_SEQ  = 2'd1,
        MODE_PAGE = 2'd2
    } sram_mode_e;

    typedef struct packed {
        sram_mode_e  mode;
        logic [5:0]  reserved;
    } mode_reg_t;

    // host write byte: payload for WRITE, mode register image for WRMR
    typedef union packed {
        byte_t      data;
        mode_reg_t  mode_reg;
    } wr_byte_u;

    // which register drives SI
    localparam logic [1:0] SEL_NONE   = 2'd0;
    localparam logic [1:0] SEL_OPCODE = 2'd1;
    localparam logic [1:0] SEL_ADDR   = 2'd2;
    localparam logic [1:0] SEL_WDATA  = 2'd3;

endpackage : sram_spi_pkg

`default_nettype wire

/* test/spi_sram_model.sv */
/*
 * Behavioral serial SPI SRAM used as the load of the controller.
 * Decodes WRMR, WRITE and READ from SI in SPI mode 0, keeps a mode register
 * and a 128 KiB array that starts filled with an address-derived pattern.
 */
`timescale 1ns/10ps
`default_nettype none

module spi_sram_model import sram_spi_pkg::*; (
    input  wire   cs_n,
    input  wire   sck,
    input  wire   si,
    input  wire   hold_n,
    output logic  so
);

    localparam int MEM_BYTES = 131072;

    byte_t       mem [0:MEM_BYTES-1];
    sram_mode_e  mode;
    mode_reg_t   mode_img;
    int          transfer_count;
    int          bit_cnt;
    byte_t       cmd;
    byte_t       in_sr;
    byte_t       out_sr;
    sram_addr_t  addr;

    initial begin
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = byte_t'(a ^ (a >> 8) ^ (a >> 13));
        end
        mode           = MODE_SEQ;
        transfer_count = 0;
        bit_cnt        = 0;
        cmd            = '0;
        addr           = '0;
        so             = 1'b0;
    end

    always @(negedge cs_n) begin
        transfer_count++;
        bit_cnt = 0;
        cmd     = '0;
    end

    // an incomplete byte is dropped here
    always @(posedge cs_n) begin
        bit_cnt = 0;
        so      = 1'b0;
    end

    // ============================================================
    // SI side, sampled on the rising edge
    // ============================================================
    always @(posedge sck) begin
        if (!cs_n && hold_n) begin
            in_sr = {in_sr[BITS_PER_BYTE-2:0], si};
            bit_cnt++;
            if (bit_cnt == 8) begin
                cmd = in_sr;
            end else if ((bit_cnt <= 32) && ((cmd == CMD_WRITE) || (cmd == CMD_READ))) begin
                addr = {addr[$high(addr)-1:0], si};
            end else if ((bit_cnt == 16) && (cmd == CMD_WRMR)) begin
                mode_img = in_sr;
                mode     = mode_img.mode;
            end else if ((bit_cnt > 32) && (bit_cnt % 8 == 0) && (cmd == CMD_WRITE)) begin
                mem[addr[16:0]] = in_sr;
                if (mode != MODE_BYTE) begin
                    addr = addr + 1'b1;
                end
            end
        end
    end

    // SO changes after the falling edge
    always @(negedge sck) begin
        if (!cs_n && hold_n && (cmd == CMD_READ) && (bit_cnt >= 32)) begin
            if (bit_cnt % 8 == 0) begin
                out_sr = mem[addr[16:0]];
                if (mode != MODE_BYTE) begin
                    addr = addr + 1'b1;
                end
            end
            so     = out_sr[BITS_PER_BYTE-1];
            out_sr = out_sr << 1;
        end
    end

endmodule : spi_sram_model

`default_nettype wire

/* test/tb_spi_sram_ctrl.sv */
/*
 * Directed testbench for the SPI SRAM controller.
 * Runs WRMR, WRITE and READ transfers against the serial SRAM model,
 * mirrors completed writes in a scoreboard and prints one line per test.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_spi_sram_ctrl import sram_spi_pkg::*; ();

    localparam int         CLK_SCK_RATIO = 6;
    localparam int         WAIT_LIMIT    = 4000;
    localparam int         STREAM_BYTES  = 5;
    localparam sram_addr_t ADDR_MASK     = 24'h01_FFF0;

    logic        clk;
    logic        reset_n;
    logic        sync_reset;
    logic        instruction_start;
    byte_t       instruction;
    sram_addr_t  address;
    byte_t       write_data;
    logic        write_data_grasp;
    logic        read_data_enable_out;
    byte_t       read_data;
    wire         mem_so;
    wire         mem_si;
    wire         mem_hold_n;
    wire         mem_cs_n;
    wire         mem_sck;

    int          seed = 10142;
    int          errors;
    int          checks;
    byte_t       sb [sram_addr_t];
    sram_addr_t  stream_addr;

    spi_sram_ctrl #(
        .CLK_SCK_RATIO (CLK_SCK_RATIO)
    ) i_spi_sram_ctrl (
        .clk                  (clk),
        .reset_n              (reset_n),
        .sync_reset           (sync_reset),
        .instruction_start    (instruction_start),
        .instruction          (instruction),
        .address              (address),
        .write_data           (write_data),
        .write_data_grasp     (write_data_grasp),
        .read_data_enable_out (read_data_enable_out),
        .read_data            (read_data),
        .mem_so               (mem_so),
        .mem_si               (mem_si),
        .mem_hold_n           (mem_hold_n),
        .mem_cs_n             (mem_cs_n),
        .mem_sck              (mem_sck)
    );

    spi_sram_model i_sram_model (
        .cs_n   (mem_cs_n),
        .sck    (mem_sck),
        .si     (mem_si),
        .hold_n (mem_hold_n),
        .so     (mem_so)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // ============================================================
    // helpers and compare tasks
    // ============================================================
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string msg);
        $display("run stopped at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $finish;
    endtask

    function automatic byte_t model_byte(input sram_addr_t a);
        return i_sram_model.mem[a[16:0]];
    endfunction

    task automatic check_byte(input string what, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s: got %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_mode(input string what, input sram_mode_e got, input sram_mode_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s: got %s, expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error at %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report(input string name, input int err_before);
        if (errors == err_before) begin
            $display("%-24s ok", name);
        end else begin
            $display("%-24s %0d error(s)", name, errors - err_before);
        end
    endtask

    task automatic start_instr(input byte_t op, input sram_addr_t addr, input byte_t data);
        instruction       = op;
        address           = addr;
        write_data        = data;
        instruction_start = 1'b1;
        tick();
        instruction_start = 1'b0;
    endtask

    task automatic wait_cs(input logic level);
        int n;
        n = 0;
        while (mem_cs_n !== level) begin
            if (n == WAIT_LIMIT) begin
                abort_run($sformatf("mem_cs_n never went to %b", level));
            end
            tick();
            n++;
        end
    endtask

    // checks the level after each edge, so the current pulse is skipped
    task automatic wait_grasp();
        int n;
        n = 0;
        tick();
        while (write_data_grasp !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                abort_run("write_data_grasp never came");
            end
            tick();
            n++;
        end
    endtask

    // counts read strobes until chip select has been high for settle cycles
    task automatic watch_reads(input int settle, output int count, output byte_t last);
        int n;
        int quiet;
        n     = 0;
        quiet = 0;
        count = 0;
        last  = '0;
        while (quiet < settle) begin
            tick();
            n++;
            if (read_data_enable_out) begin
                count++;
                last = read_data;
            end
            if (mem_cs_n) begin
                quiet++;
            end
            if (n > WAIT_LIMIT) begin
                abort_run("transfer never ended");
            end
        end
    endtask

    task automatic write_mode(input sram_mode_e m);
        wr_byte_u mr;
        mr.mode_reg.mode     = m;
        mr.mode_reg.reserved = '0;
        start_instr(CMD_WRMR, '0, mr.data);
        wait_cs(1'b0);
        wait_cs(1'b1);
    endtask

    // ============================================================
    // directed tests
    // ============================================================
    task automatic test_reset();
        int e0;
        e0 = errors;
        check_level("mem_cs_n after reset", mem_cs_n, 1'b1);
        check_level("mem_sck after reset", mem_sck, 1'b0);
        check_level("mem_si after reset", mem_si, 1'b0);
        check_level("mem_hold_n after reset", mem_hold_n, 1'b1);
        check_level("grasp after reset", write_data_grasp, 1'b0);
        check_level("read strobe after reset", read_data_enable_out, 1'b0);
        check_mode("model mode after reset", i_sram_model.mode, MODE_SEQ);
        report("reset", e0);
    endtask

    task automatic test_byte_mode();
        int          e0;
        int          cnt;
        sram_addr_t  a;
        byte_t       d;
        byte_t       got;
        e0 = errors;
        write_mode(MODE_BYTE);
        check_mode("model mode after WRMR", i_sram_model.mode, MODE_BYTE);
        a = sram_addr_t'($random(seed)) & ADDR_MASK;
        d = byte_t'($random(seed));
        start_instr(CMD_WRITE, a, d);
        wait_cs(1'b0);
        wait_cs(1'b1);
        sb[a] = d;
        check_byte("model byte after WRITE", model_byte(a), sb[a]);
        start_instr(CMD_READ, a, '0);
        wait_cs(1'b0);
        watch_reads(2 * CLK_SCK_RATIO, cnt, got);
        check_count("read strobes in byte mode", cnt, 1);
        check_byte("byte mode read", got, sb[a]);
        report("byte mode", e0);
    endtask

    task automatic test_seq_write();
        int     e0;
        byte_t  d;
        byte_t  cur;
        byte_t  past;
        e0 = errors;
        write_mode(MODE_SEQ);
        check_mode("model mode after WRMR", i_sram_model.mode, MODE_SEQ);
        stream_addr = sram_addr_t'($random(seed)) & ADDR_MASK;
        past        = model_byte(stream_addr + STREAM_BYTES);
        d           = byte_t'($random(seed));
        start_instr(CMD_WRITE, stream_addr, d);
        check_level("grasp after start", write_data_grasp, 1'b1);
        // each grasp marks the previous byte as written
        for (int i = 0; i < STREAM_BYTES; i++) begin
            cur        = d;
            d          = byte_t'($random(seed));
            write_data = d;
            wait_grasp();
            sb[sram_addr_t'(stream_addr + i)] = cur;
        end
        sync_reset = 1'b1;
        tick();
        sync_reset = 1'b0;
        check_level("mem_cs_n after abort", mem_cs_n, 1'b1);
        for (int i = 0; i < STREAM_BYTES; i++) begin
            check_byte($sformatf("stream byte %0d", i),
                       model_byte(stream_addr + i), sb[sram_addr_t'(stream_addr + i)]);
        end
        check_byte("byte past the stream", model_byte(stream_addr + STREAM_BYTES), past);
        report("sequential write", e0);
    endtask

    task automatic test_seq_read();
        int     e0;
        int     i;
        int     n;
        int     cnt;
        byte_t  last;
        e0 = errors;
        i  = 0;
        n  = 0;
        start_instr(CMD_READ, stream_addr, '0);
        while (i < STREAM_BYTES) begin
            tick();
            n++;
            if (read_data_enable_out) begin
                check_byte($sformatf("stream read %0d", i),
                           read_data, sb[sram_addr_t'(stream_addr + i)]);
                i++;
            end
            if (n > WAIT_LIMIT) begin
                abort_run("read stream stalled");
            end
        end
        sync_reset = 1'b1;
        tick();
        sync_reset = 1'b0;
        check_level("mem_cs_n after abort", mem_cs_n, 1'b1);
        watch_reads(2 * BITS_PER_BYTE * CLK_SCK_RATIO, cnt, last);
        check_count("read strobes after abort", cnt, 0);
        report("sequential read", e0);
    endtask

    task automatic test_start_busy();
        int          e0;
        int          cnt;
        int          xfers;
        sram_addr_t  a;
        byte_t       got;
        e0 = errors;
        write_mode(MODE_BYTE);
        a     = sram_addr_t'(stream_addr + 2);
        xfers = i_sram_model.transfer_count;
        start_instr(CMD_READ, a, '0);
        wait_cs(1'b0);
        // land the second start in the middle of the opcode
        repeat (4 * CLK_SCK_RATIO) tick();
        start_instr(CMD_WRITE, a, ~sb[a]);
        watch_reads(2 * CLK_SCK_RATIO, cnt, got);
        check_count("read strobes", cnt, 1);
        check_byte("read with start while busy", got, sb[a]);
        check_count("transfers seen by model", i_sram_model.transfer_count - xfers, 1);
        check_byte("memory after ignored WRITE", model_byte(a), sb[a]);
        report("start while busy", e0);
    endtask

    initial begin
        errors            = 0;
        checks            = 0;
        reset_n           = 1'b0;
        sync_reset        = 1'b0;
        instruction_start = 1'b0;
        instruction       = '0;
        address           = '0;
        write_data        = '0;
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;
        tick();

        test_reset();
        test_byte_mode();
        test_seq_write();
        test_seq_read();
        test_start_busy();

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_spi_sram_ctrl

`default_nettype wire
